// File: hw/spi_reg_consts.svh
// widths and sizes shared by the spi register bank
// include wherever a byte, an address or the sync depth is needed
`ifndef SPI_REG_CONSTS_SVH
`define SPI_REG_CONSTS_SVH

// bits per spi transfer
`define SPI_BYTE_BITS 8

// full address space, pointer wraps here
`define SPI_REG_COUNT 16

// addresses below this are rw, the rest read status bytes
`define SPI_REG_WR_COUNT 12

// flops per pin synchronizer, at least 2
`define SPI_SYNC_STAGES 2

`endif

// File: hw/spi_reg_pkg.sv
// struct types passed between the spi front end, shifter and command stage
// referenced by scoped name from each module
`default_nettype none

`include "spi_reg_consts.svh"

package spi_reg_pkg;

	// raw pins as they arrive at the top
	typedef struct packed {
		logic cs;                               // chip select, active low
		logic sclk;                             // master clock, async to sys_clk
		logic mosi;                             // master out
	} spi_pins_t;

	// front end to shifter, all synchronous to sys_clk
	typedef struct packed {
		logic sel;                              // cs low, synced
		logic start;                            // cs fall pulse
		logic sample;                           // capture mosi now
		logic shift;                            // present next miso bit
	} spi_strobe_t;

	// shifter to command stage
	typedef struct packed {
		logic [`SPI_BYTE_BITS-1:0] data;        // last completed byte
		logic                      done;        // one cycle per byte
		logic                      first;       // byte is the command
	} spi_byte_t;

	// parallel write port toward downstream logic
	typedef struct packed {
		logic                               en;     // one cycle strobe
		logic [$clog2(`SPI_REG_COUNT)-1:0]  addr;   // register index
		logic [`SPI_BYTE_BITS-1:0]          data;   // written byte
	} reg_wr_t;

endpackage

`default_nettype wire

// File: hw/spi_edge_sync.sv
// spi pin front end: synchronizes cs, sclk and mosi into sys_clk
// and turns sclk transitions into sample and shift strobes for the mode
`timescale 1ns/10ps
`default_nettype none

`include "spi_reg_consts.svh"

module spi_edge_sync #(
	parameter bit CPOL = 1'b0,                  // sclk idle level
	parameter bit CPHA = 1'b0                   // 0: sample on leading edge
) (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  spi_reg_pkg::spi_pins_t    pins,     // async pins
	output spi_reg_pkg::spi_strobe_t  strb,     // registered strobes
	output logic                      mosi_sync // aligned with strb
);

	// idle bus: cs high, sclk at cpol
	localparam spi_reg_pkg::spi_pins_t PINS_IDLE = '{cs: 1'b1, sclk: CPOL, mosi: 1'b0};

	spi_reg_pkg::spi_pins_t [`SPI_SYNC_STAGES-1:0] pin_sync;  // synchronizer chain
	spi_reg_pkg::spi_pins_t pin_s;              // synchronizer output
	logic cs_d;                                 // delayed cs, for edge detect
	logic sclk_d;                               // delayed sclk
	logic sel_now;                              // cs active this cycle
	logic cs_fall;
	logic lead_edge;                            // away from cpol level
	logic trail_edge;                           // back to cpol level

	assign pin_s   = pin_sync[`SPI_SYNC_STAGES-1];
	assign sel_now = ~pin_s.cs;
	assign cs_fall = cs_d & ~pin_s.cs;

	// edges only count inside a frame
	assign lead_edge  = sel_now & (sclk_d == CPOL) & (pin_s.sclk != CPOL);
	assign trail_edge = sel_now & (sclk_d != CPOL) & (pin_s.sclk == CPOL);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pin_sync <= {`SPI_SYNC_STAGES{PINS_IDLE}};
			cs_d     <= 1'b1;                   // no false start out of reset
			sclk_d   <= CPOL;
			strb     <= '0;
		end else begin
			pin_sync     <= {pin_sync[`SPI_SYNC_STAGES-2:0], pins};
			cs_d         <= pin_s.cs;
			sclk_d       <= pin_s.sclk;
			strb.sel     <= sel_now;
			strb.start   <= cs_fall;
			strb.sample  <= CPHA ? trail_edge : lead_edge;  // mode 0/2 sample leading
			strb.shift   <= CPHA ? lead_edge : trail_edge;
		end
	end

	// one more stage so mosi lines up with the sample strobe
	always_ff @(posedge sys_clk) begin
		mosi_sync <= pin_s.mosi;
	end

endmodule

`default_nettype wire

// File: hw/spi_slave.sv
// spi bit engine: builds mosi bytes on sample strobes, shifts the
// transmit byte out on miso and flags each completed byte
// tx_data is reloaded at frame start and one cycle after every byte
`timescale 1ns/10ps
`default_nettype none

`include "spi_reg_consts.svh"

module spi_slave (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  spi_reg_pkg::spi_strobe_t   strb,
	input  logic                       mosi_sync,
	input  logic [`SPI_BYTE_BITS-1:0]  tx_data,    // next byte to send
	output logic                       miso,
	output spi_reg_pkg::spi_byte_t     rx
);

	localparam int CW = $clog2(`SPI_BYTE_BITS);
	localparam logic [CW-1:0] LAST_BIT = CW'(`SPI_BYTE_BITS - 1);

	logic [`SPI_BYTE_BITS-1:0] rx_shift;        // msb first
	logic [`SPI_BYTE_BITS-1:0] tx_shift;        // top bit on miso
	logic [CW-1:0]             bit_cnt;         // samples taken in this byte
	logic                      done_r;
	logic                      done_d;          // reload slot for tx_shift
	logic                      first_pend;      // next byte is a command

	assign miso = strb.sel & tx_shift[`SPI_BYTE_BITS-1];  // quiet outside a frame

	assign rx.data  = rx_shift;
	assign rx.done  = done_r;
	assign rx.first = first_pend;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bit_cnt    <= '0;
			done_r     <= 1'b0;
			done_d     <= 1'b0;
			first_pend <= 1'b1;
		end else begin
			done_r <= strb.sample & (bit_cnt == LAST_BIT);
			done_d <= done_r;

			if (!strb.sel)
				bit_cnt <= '0;                  // cs high drops partial byte
			else if (strb.sample)
				bit_cnt <= bit_cnt + 1'b1;      // wraps after eighth bit

			if (!strb.sel)
				first_pend <= 1'b1;             // held while idle
			else if (done_r)
				first_pend <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (strb.sample)
			rx_shift <= {rx_shift[`SPI_BYTE_BITS-2:0], mosi_sync};

		// a shift at bit 0 would skip the freshly loaded msb, so hold it
		if (strb.start || done_d)
			tx_shift <= tx_data;
		else if (strb.shift && bit_cnt != '0)
			tx_shift <= {tx_shift[`SPI_BYTE_BITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: hw/spi_reg_cmd.sv
// frame decoder and register bank behind the spi slave
// first byte of a frame is the command: bit 7 write, bits 3:0 start address
// later bytes write or read at an auto-incrementing pointer
// upper addresses map the status word, lsb first
`timescale 1ns/10ps
`default_nettype none

`include "spi_reg_consts.svh"

module spi_reg_cmd (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  spi_reg_pkg::spi_byte_t       rx,
	input  logic [4*`SPI_BYTE_BITS-1:0]  status,   // read-only word
	output logic [`SPI_BYTE_BITS-1:0]    tx_data,  // byte the slave sends next
	output spi_reg_pkg::reg_wr_t         reg_wr
);

	localparam int AW = $clog2(`SPI_REG_COUNT);
	localparam logic [AW-1:0] WR_LIMIT = AW'(`SPI_REG_WR_COUNT);

	logic [`SPI_BYTE_BITS-1:0] regs [`SPI_REG_WR_COUNT];  // rw bank
	logic [AW-1:0]             ptr;             // current address
	logic [AW-1:0]             rd_addr;         // address tx_data will show
	logic [`SPI_BYTE_BITS-1:0] rd_val;
	logic                      wr_mode;         // latched from command bit 7
	logic                      wr_hit;          // data byte lands in the bank
	logic                      wr_en;
	logic [AW-1:0]             wr_addr;
	logic [`SPI_BYTE_BITS-1:0] wr_data;

	assign reg_wr.en   = wr_en;
	assign reg_wr.addr = wr_addr;
	assign reg_wr.data = wr_data;

	// command sets the pointer, data bytes step it, 4 bits wrap at 16
	assign rd_addr = rx.first ? rx.data[AW-1:0] : ptr + 1'b1;
	assign wr_hit  = rx.done & ~rx.first & wr_mode & (ptr < WR_LIMIT);

	// status region starts on a multiple of 4, so low bits pick the byte
	always_comb begin
		if (rd_addr < WR_LIMIT)
			rd_val = regs[rd_addr];
		else
			rd_val = status[rd_addr[1:0] * `SPI_BYTE_BITS +: `SPI_BYTE_BITS];
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			wr_mode <= 1'b0;
			ptr     <= '0;
			tx_data <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en <= wr_hit;                    // one cycle after byte done
			if (rx.done && rx.first) begin
				wr_mode <= rx.data[`SPI_BYTE_BITS-1];
				ptr     <= rx.data[AW-1:0];
			end else if (rx.done) begin
				ptr <= ptr + 1'b1;
			end

			if (rx.done)
				tx_data <= rd_val;              // value at the new pointer
			else if (rx.first)
				tx_data <= '0;                  // command byte returns zero
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < `SPI_REG_WR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[ptr] <= rx.data;
		end
	end

	// write port payload, qualified by wr_en
	always_ff @(posedge sys_clk) begin
		if (wr_hit) begin
			wr_addr <= ptr;
			wr_data <= rx.data;
		end
	end

endmodule

`default_nettype wire

// File: hw/spi_reg_top.sv
// spi slave register bank top: pin front end, bit engine, command stage
// CPOL/CPHA select the spi mode, sclk half period must be >= 6 sys_clk
`timescale 1ns/10ps
`default_nettype none

`include "spi_reg_consts.svh"

module spi_reg_top #(
	parameter bit CPOL = 1'b0,
	parameter bit CPHA = 1'b0
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  spi_reg_pkg::spi_pins_t       pins,
	input  logic [4*`SPI_BYTE_BITS-1:0]  status,
	output logic                         miso,
	output spi_reg_pkg::reg_wr_t         reg_wr
);

	spi_reg_pkg::spi_strobe_t  strb;            // front end strobes
	logic                      mosi_sync;
	spi_reg_pkg::spi_byte_t    rx;              // received bytes
	logic [`SPI_BYTE_BITS-1:0] tx_data;         // bank to shifter

	spi_edge_sync #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) u_edge_sync (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.pins      (pins),
		.strb      (strb),
		.mosi_sync (mosi_sync)
	);

	spi_slave u_slave (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.strb      (strb),
		.mosi_sync (mosi_sync),
		.tx_data   (tx_data),
		.miso      (miso),
		.rx        (rx)
	);

	spi_reg_cmd u_cmd (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (rx),
		.status    (status),
		.tx_data   (tx_data),
		.reg_wr    (reg_wr)
	);

endmodule

`default_nettype wire

// File: bench/spi_reg_tb.sv
// testbench for the spi register bank: bit-banged spi master task,
// reference register model, immediate and concurrent assertions
// CPOL/CPHA select the spi mode, run once per mode from the build script
`timescale 1ns/10ps
`default_nettype none

`include "spi_reg_consts.svh"

module spi_reg_tb #(
	parameter bit CPOL = 1'b0,
	parameter bit CPHA = 1'b0
);

	localparam int HALF = 8;                    // sclk half period, sys_clk cycles
	localparam int TOTAL_BYTES = 34;            // bytes sent over all frames
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 * 2 * HALF * 6 / 5;  // +20 percent

	logic                   sys_clk = 1'b0;
	logic                   sys_rst_n;
	spi_reg_pkg::spi_pins_t pins;
	logic [31:0]            status;
	logic                   miso;
	spi_reg_pkg::reg_wr_t   reg_wr;

	logic [7:0]  ref_regs [`SPI_REG_WR_COUNT];  // model of the rw bank
	logic [11:0] wr_seen [$];                   // {addr, data} per reg_wr pulse
	logic [11:0] wr_exp [$];                    // pulses the model predicts
	logic [31:0] rng_state = 32'hdb944263;
	int          check_cnt = 0;
	int          err_cnt = 0;                   // immediate assertion failures
	int          prop_err_cnt = 0;              // concurrent assertion failures
	int          cycle_cnt;

	always #2 sys_clk = ~sys_clk;               // 4 ns period

	spi_reg_top #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) UUT (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.pins      (pins),
		.status    (status),
		.miso      (miso),
		.reg_wr    (reg_wr)
	);

	// status addresses never reach the write port
	wr_in_bank: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		reg_wr.en |-> (reg_wr.addr < `SPI_REG_WR_COUNT))
	else begin
		prop_err_cnt++;
		$display("ERROR reg_wr.addr expected below %h got %h", `SPI_REG_WR_COUNT, reg_wr.addr);
	end

	always @(negedge sys_clk) begin
		if (reg_wr.en)
			wr_seen.push_back({reg_wr.addr, reg_wr.data});  // en lasts one cycle
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// what a read at addr returns, bank below 12, status word lsb first above
	function automatic logic [7:0] model_read(input logic [3:0] addr);
		logic [31:0] word;
		if (addr < `SPI_REG_WR_COUNT)
			return ref_regs[addr];
		word = status >> (8 * (addr - 4'd12));
		return word[7:0];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		check_cnt++;
		assert (act == exp)
		else begin
			err_cnt++;
			$display("ERROR %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_idle();
		compare_value("reg_wr.en", 32'h0, 32'(reg_wr.en));
		compare_value("miso", 32'h0, 32'(miso));
	endtask

	// one byte msb first, nbits below 8 stops early for an aborted byte
	task automatic xfer_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		rx = 8'h00;
		for (int i = 7; i > 7 - nbits; i--) begin
			if (!CPHA)
				pins.mosi = tx[i];              // set up before leading edge
			repeat (HALF) @(negedge sys_clk);
			if (!CPHA)
				rx[i] = miso;
			pins.sclk = ~CPOL;                  // leading edge
			if (CPHA)
				pins.mosi = tx[i];
			repeat (HALF) @(negedge sys_clk);
			if (CPHA)
				rx[i] = miso;
			pins.sclk = CPOL;                   // trailing edge
		end
	endtask

	// command byte then n_data bytes, miso and reg_wr checked against the model
	task automatic spi_frame(input bit wr, input logic [3:0] start, input int n_data,
			input int cut_bits);
		logic [7:0] got;
		logic [7:0] tx;
		logic [3:0] ptr;
		int         nbits;
		int         first_wr;
		first_wr = wr_seen.size();
		wr_exp.delete();
		rng_state = xorshift32(rng_state);
		pins.cs = 1'b0;
		xfer_byte({wr, rng_state[6:4], start}, 8, got);  // bits 6:4 are don't care
		compare_value("miso command byte", 32'h0, 32'(got));
		ptr = start;
		for (int i = 0; i < n_data; i++) begin
			rng_state = xorshift32(rng_state);
			tx = rng_state[7:0];
			nbits = (cut_bits != 0 && i == n_data - 1) ? cut_bits : 8;
			xfer_byte(tx, nbits, got);
			if (nbits == 8) begin
				compare_value("miso", 32'(model_read(ptr)), 32'(got));  // old value
				if (wr && ptr < `SPI_REG_WR_COUNT) begin
					ref_regs[ptr] = tx;
					wr_exp.push_back({ptr, tx});
				end
				ptr = ptr + 4'd1;               // wraps at 16
			end
		end
		repeat (HALF) @(negedge sys_clk);
		pins.cs = 1'b1;
		repeat (2 * HALF) @(negedge sys_clk);   // let the last write drain
		compare_value("reg_wr pulse count", wr_exp.size(), wr_seen.size() - first_wr);
		for (int i = 0; i < wr_exp.size() && first_wr + i < wr_seen.size(); i++) begin
			compare_value("reg_wr.addr", 32'(wr_exp[i][11:8]), 32'(wr_seen[first_wr+i][11:8]));
			compare_value("reg_wr.data", 32'(wr_exp[i][7:0]), 32'(wr_seen[first_wr+i][7:0]));
		end
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("run stopped, tests still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin : stimulus
		sys_rst_n = 1'b0;
		pins = '{cs: 1'b1, sclk: CPOL, mosi: 1'b0};
		rng_state = xorshift32(rng_state);
		status = rng_state;
		for (int i = 0; i < `SPI_REG_WR_COUNT; i++) begin
			ref_regs[i] = 8'h00;
		end
		repeat (10) begin
			@(negedge sys_clk);
			check_idle();                       // quiet during reset
		end
		sys_rst_n = 1'b1;
		repeat (HALF) begin
			@(negedge sys_clk);
			check_idle();                       // cs still high
		end
		spi_frame(1'b1, 4'd3, 1, 0);            // single write
		spi_frame(1'b1, 4'd10, 9, 0);           // burst wraps past status bytes
		spi_frame(1'b1, 4'd5, 1, 5);            // cs rises after 5 bits
		spi_frame(1'b1, 4'd7, 1, 0);            // first byte is a command again
		spi_frame(1'b0, 4'd0, 12, 0);           // read back the bank
		rng_state = xorshift32(rng_state);
		status = rng_state;
		spi_frame(1'b0, 4'd12, 4, 0);           // status bytes, lsb first
		$display("checks %0d, failed checks %0d, failed properties %0d",
			check_cnt, err_cnt, prop_err_cnt);
		if (err_cnt == 0 && prop_err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/spi_reg_pkg.sv
hw/spi_edge_sync.sv
hw/spi_slave.sv
hw/spi_reg_cmd.sv
hw/spi_reg_top.sv
bench/spi_reg_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the spi register bank testbench once for each spi mode
set -e
cd "$(dirname "$0")"

for mode in 0 1 2 3; do
	cpol=$((mode / 2))
	cpha=$((mode % 2))
	build="build_mode$mode"
	log="sim_mode$mode.log"
	verilator --binary --timing --assert -Wno-fatal \
		--top-module spi_reg_tb -GCPOL=$cpol -GCPHA=$cpha \
		--Mdir "$build" -o sim -f list.f
	"./$build/sim" > "$log"
	cat "$log"
	if grep -qx "No errors" "$log"; then
		echo "mode $mode passed"
	else
		echo "mode $mode failed, see $log"
		exit 1
	fi
done
echo "all four spi modes passed"
